// ==== design/qla_pkg.sv ====
// QLA motor channel shared definitions
`default_nettype none

package qla_pkg;

    // ------------------------------------------------------------------------
    // sizing
    // ------------------------------------------------------------------------
    localparam int NUM_AXES     = 4;                       // motor axes on the board
    localparam int REQ_DEPTH    = 4;                       // queue depth = initial credits
    localparam int SAFETY_LIMIT = 4;                       // overcurrent cycles before trip

    localparam int QPTR_W = $clog2(REQ_DEPTH);             // queue pointer width
    localparam int AXIS_W = $clog2(NUM_AXES);              // axis index width
    localparam int CNT_W  = $clog2(SAFETY_LIMIT + 1);      // persistence counter width
    localparam int CHAN_W = 3;                             // channels 0..4
    localparam int OFF_W  = 4;                             // low nibble of the address

    // ------------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------------
    // addr[7:4] is the channel, addr[3:0] the offset, addr[15:8] must be zero
    localparam logic [CHAN_W-1:0] ADDR_CHAN0   = 3'd0;      // board registers
    localparam logic [OFF_W-1:0]  OFF_ADC_DATA = 4'd0;      // axis feedback current
    localparam logic [OFF_W-1:0]  OFF_DAC_CTRL = 4'd1;      // axis current command
    localparam logic [OFF_W-1:0]  OFF_STATUS   = 4'd0;      // chan 0 status/control

    localparam int CLR_BIT = 8;                             // status write: clear latches

    // host opcode
    typedef enum logic {
        REG_READ  = 1'b0,
        REG_WRITE = 1'b1
    } reg_op_e;

    // one host request
    typedef struct packed {
        reg_op_e     op;
        logic [15:0] addr;
        logic [31:0] wdata;
    } reg_req_t;

    // write strobe to the register blocks, data travels beside it
    typedef struct packed {
        logic              wen;
        logic [CHAN_W-1:0] chan;
        logic [OFF_W-1:0]  offset;
    } reg_wr_t;

    typedef logic [NUM_AXES-1:0][15:0] cur_vec_t;           // index 0 is axis 1
    typedef logic [NUM_AXES-1:0]       axis_mask_t;         // bit 0 is axis 1

endpackage

`default_nettype wire

// ==== design/reg_port.sv ====
// Host request queue and register port
`timescale 1ns/1ps
`default_nettype none

module reg_port (
    input  logic              sysclk,
    input  logic              rst_n,
    input  logic              req_valid,   // one request per cycle, credit guarded
    input  qla_pkg::reg_req_t req,
    output logic              credit,      // one pulse per pop
    output logic              rsp_valid,
    output logic [31:0]       rsp_data,
    output qla_pkg::reg_wr_t  wr,          // registered write strobe
    output logic [31:0]       wdata,
    input  qla_pkg::cur_vec_t fb,
    input  qla_pkg::cur_vec_t cmd,
    input  logic [31:0]       status_word
);
    import qla_pkg::*;

    reg_req_t          mem [REQ_DEPTH];    // queue storage
    logic [QPTR_W-1:0] head;               // next entry out
    logic [QPTR_W-1:0] tail;               // next free slot
    logic [QPTR_W:0]   count;              // entries held
    logic              push;
    logic              pop;
    reg_req_t          head_req;
    logic              head_map;           // head address hits a channel
    logic              rd_pend;            // read popped last edge
    logic              rd_hit;             // and it was mapped
    logic [AXIS_W-1:0] axis_idx;
    logic [31:0]       rd_sel;

    function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] p);
        return (p == QPTR_W'(REQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ------------------------------------------------------------------------
    // request queue
    // ------------------------------------------------------------------------
    assign push = req_valid;               // host never sends without credit
    assign pop  = (count != '0);           // drain one per cycle

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push)
                tail <= ptr_inc(tail);
            if (pop)
                head <= ptr_inc(head);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
            credit <= pop;                 // slot freed, hand it back
        end
    end

    always_ff @(posedge sysclk) begin
        if (push)
            mem[tail] <= req;
    end

    // ------------------------------------------------------------------------
    // decode of the popped entry
    // ------------------------------------------------------------------------
    assign head_req = mem[head];
    assign head_map = (head_req.addr[15:8] == 8'h00) &&
                      (head_req.addr[7:4] <= 4'(NUM_AXES));

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wr      <= '0;
            rd_pend <= 1'b0;
            rd_hit  <= 1'b0;
        end else begin
            wr.wen <= pop && head_map && (head_req.op == REG_WRITE);
            if (pop) begin
                wr.chan   <= head_req.addr[4 +: CHAN_W];   // kept for the read mux too
                wr.offset <= head_req.addr[OFF_W-1:0];
            end
            rd_pend <= pop && (head_req.op == REG_READ);
            rd_hit  <= pop && head_map && (head_req.op == REG_READ);
        end
    end

    always_ff @(posedge sysclk) begin
        if (pop)
            wdata <= head_req.wdata;
    end

    // ------------------------------------------------------------------------
    // read data mux and response
    // ------------------------------------------------------------------------
    assign axis_idx = AXIS_W'(wr.chan - 1'b1);   // chan 1..4 -> 0..3

    always_comb begin
        rd_sel = '0;                             // unmapped offsets read zero
        if (wr.chan == ADDR_CHAN0) begin
            if (wr.offset == OFF_STATUS)
                rd_sel = status_word;
        end else if (wr.offset == OFF_ADC_DATA) begin
            rd_sel = {16'h0000, fb[axis_idx]};
        end else if (wr.offset == OFF_DAC_CTRL) begin
            rd_sel = {16'h0000, cmd[axis_idx]};
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= rd_pend;
    end

    always_ff @(posedge sysclk) begin
        if (rd_pend)
            rsp_data <= rd_hit ? rd_sel : '0;
    end

endmodule

`default_nettype wire

// ==== design/dac_regs.sv ====
// Per-axis current command registers
`timescale 1ns/1ps
`default_nettype none

module dac_regs (
    input  logic              sysclk,
    input  logic              rst_n,
    input  qla_pkg::reg_wr_t  wr,
    input  logic [31:0]       wdata,       // low half is the setpoint
    output qla_pkg::cur_vec_t cmd          // dac setpoints, axis 1 at index 0
);
    import qla_pkg::*;

    axis_mask_t axis_we;                   // per-axis write enable

    // channel n+1, offset OFF_DAC_CTRL hits axis n
    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            axis_we[i] = wr.wen &&
                         (wr.chan == CHAN_W'(i + 1)) &&
                         (wr.offset == OFF_DAC_CTRL);
        end
    end

    // ------------------------------------------------------------------------
    // command registers
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cmd <= '0;                     // amps commanded to zero
        end else begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (axis_we[i])
                    cmd[i] <= wdata[15:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/safety_check.sv ====
// Overcurrent persistence check
`timescale 1ns/1ps
`default_nettype none

module safety_check (
    input  logic                sysclk,
    input  logic                rst_n,
    input  qla_pkg::cur_vec_t   fb,            // measured current
    input  qla_pkg::cur_vec_t   cmd,           // commanded current
    input  logic                safety_clear,  // drops all latches
    output qla_pkg::axis_mask_t disable_mask   // latched amp disable per axis
);
    import qla_pkg::*;

    logic [CNT_W-1:0] cnt [NUM_AXES];          // consecutive overcurrent cycles
    axis_mask_t       over;                    // fb > 2 * cmd this cycle

    // compare at 17 bits so 2*cmd cannot wrap
    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            over[i] = {1'b0, fb[i]} > {cmd[i], 1'b0};
        end
    end

    // ------------------------------------------------------------------------
    // counters and latches
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AXES; i++)
                cnt[i] <= '0;
            disable_mask <= '0;
        end else if (safety_clear) begin
            for (int i = 0; i < NUM_AXES; i++)
                cnt[i] <= '0;                  // restart persistence from scratch
            disable_mask <= '0;
        end else begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (!over[i])
                    cnt[i] <= '0;              // any good sample restarts the run
                else if (cnt[i] != CNT_W'(SAFETY_LIMIT))
                    cnt[i] <= cnt[i] + 1'b1;   // saturate at the limit
                if (cnt[i] == CNT_W'(SAFETY_LIMIT))
                    disable_mask[i] <= 1'b1;   // sticky until cleared
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/board_regs.sv ====
// Channel 0 board status and control
`timescale 1ns/1ps
`default_nettype none

module board_regs (
    input  logic                sysclk,
    input  logic                rst_n,
    input  qla_pkg::reg_wr_t    wr,
    input  logic [31:0]         wdata,
    input  logic [3:0]          board_id,      // rotary switch
    input  qla_pkg::axis_mask_t disable_mask,  // from safety_check
    output logic [31:0]         status_word,   // read back at chan 0 offset 0
    output logic                safety_clear,  // one-cycle pulse
    output qla_pkg::axis_mask_t amp_active     // enable and not tripped
);
    import qla_pkg::*;

    axis_mask_t amp_enable;                    // host enable bits
    logic       status_we;                     // write to the status register

    assign status_we = wr.wen &&
                       (wr.chan == ADDR_CHAN0) &&
                       (wr.offset == OFF_STATUS);

    // ------------------------------------------------------------------------
    // control bits
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            amp_enable   <= '0;                // amps off out of reset
            safety_clear <= 1'b0;
        end else begin
            if (status_we)
                amp_enable <= wdata[NUM_AXES-1:0];
            safety_clear <= status_we && wdata[CLR_BIT];   // self clearing
        end
    end

    // ------------------------------------------------------------------------
    // status word
    // ------------------------------------------------------------------------
    // [27:24] board id, [11:8] latched disable, [3:0] enable
    assign status_word = {4'h0, board_id,
                          12'h000, disable_mask,
                          4'h0, amp_enable};

    // tripped axes stay off even with enable set
    assign amp_active = amp_enable & ~disable_mask;

endmodule

`default_nettype wire

// ==== design/qla_ctrl.sv ====
// QLA four-axis controller core
`timescale 1ns/1ps
`default_nettype none

module qla_ctrl (
    input  logic                sysclk,
    input  logic                rst_n,

    // host side
    input  logic                req_valid,
    input  qla_pkg::reg_req_t   req,
    output logic                credit,
    output logic                rsp_valid,
    output logic [31:0]         rsp_data,

    // amplifier side
    input  qla_pkg::cur_vec_t   fb,           // feedback currents, parallel
    input  logic [3:0]          board_id,
    output qla_pkg::cur_vec_t   cmd,          // current setpoints, parallel
    output qla_pkg::axis_mask_t amp_active
);
    import qla_pkg::*;

    // ------------------------------------------------------------------------
    // local wires between the blocks
    // ------------------------------------------------------------------------
    reg_wr_t     wr;                          // registered write strobe
    logic [31:0] wdata;                       // write data beside the strobe
    logic [31:0] status_word;                 // chan 0 read data
    logic        safety_clear;
    axis_mask_t  disable_mask;

    reg_port u_reg_port (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),     // in: host request
        .req         (req),
        .credit      (credit),        // out: credit return
        .rsp_valid   (rsp_valid),     // out: read response
        .rsp_data    (rsp_data),
        .wr          (wr),            // out: strobe to register blocks
        .wdata       (wdata),
        .fb          (fb),            // in: adc data reads
        .cmd         (cmd),           // in: dac readback
        .status_word (status_word)    // in: chan 0 readback
    );

    dac_regs u_dac_regs (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .wr     (wr),
        .wdata  (wdata),
        .cmd    (cmd)
    );

    // 1. feedback vs command every cycle  2. latch on persistent overcurrent
    safety_check u_safety_check (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .fb           (fb),
        .cmd          (cmd),
        .safety_clear (safety_clear),
        .disable_mask (disable_mask)
    );

    board_regs u_board_regs (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .wr           (wr),
        .wdata        (wdata),
        .board_id     (board_id),
        .disable_mask (disable_mask),
        .status_word  (status_word),
        .safety_clear (safety_clear),
        .amp_active   (amp_active)
    );

endmodule

`default_nettype wire

// ==== verification/qla_ctrl_asserts.sv ====
// Request queue and response timing checks
`timescale 1ns/1ps
`default_nettype none

module qla_ctrl_asserts (
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  logic [qla_pkg::QPTR_W:0] count,   // entries held in the queue
    input  logic                   push,
    input  logic                   pop,
    input  qla_pkg::reg_op_e       head_op,   // op of the entry at the head
    input  logic                   credit,
    input  logic                   rsp_valid
);
    import qla_pkg::*;

    logic rd_pop;                             // read leaving the queue this edge

    assign rd_pop = pop && (head_op == REG_READ);

    // ------------------------------------------------------------------------
    // queue occupancy
    // ------------------------------------------------------------------------
    a_count_max: assert property (@(posedge sysclk) disable iff (!rst_n)
        int'(count) <= REQ_DEPTH)
        else $error("request queue holds more than its depth");

    a_no_push_full: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(push && (int'(count) == REQ_DEPTH)))
        else $error("request pushed into a full queue");

    // response two edges after a read pop, and never otherwise
    a_rsp_timing: assert property (@(posedge sysclk) disable iff (!rst_n)
        rsp_valid == $past(rd_pop, 2))
        else $error("read response out of step with the read pop");

    a_credit_pop: assert property (@(posedge sysclk) disable iff (!rst_n)
        credit |-> $past(pop))
        else $error("credit returned without a pop");

endmodule

`default_nettype wire

// ==== verification/qla_ctrl_tb.sv ====
// QLA controller core testbench
`timescale 1ns/1ps
`default_nettype none

module qla_ctrl_tb;
    import qla_pkg::*;

    localparam int CLK_PERIOD      = 4;             // ns
    localparam int RST_CYCLES      = 10;
    localparam int CYCLES_PER_CASE = 20;            // watchdog budget per line
    localparam int DRAIN_CYCLES    = 4 * REQ_DEPTH; // well past the longest round trip
    localparam int WORDS_PER_CASE  = 8;             // op addr wdata fb1..fb4 expect
    localparam int MAX_CASES       = 64;
    localparam logic [3:0]  BOARD_ID = 4'ha;        // rotary switch value
    localparam logic [31:0] OP_READ  = 32'h0;
    localparam logic [31:0] OP_WRITE = 32'h1;
    localparam logic [31:0] OP_AMP   = 32'h2;       // check amp_active
    localparam logic [31:0] OP_CMD   = 32'h3;       // check cmd of one axis
    localparam logic [31:0] OP_BURST = 32'h4;
    localparam logic [31:0] OP_END   = 32'hf;

    logic        sysclk;
    logic        rst_n;
    logic        req_valid;
    reg_req_t    req;
    logic        credit;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    cur_vec_t    fb;
    logic [3:0]  board_id;
    cur_vec_t    cmd;
    axis_mask_t  amp_active;

    logic [31:0] case_mem [MAX_CASES*WORDS_PER_CASE];
    logic [31:0] exp_q [$];                         // read data owed, issue order
    logic [15:0] shadow_cmd [NUM_AXES];             // host view of the setpoints
    int          host_credits;
    int          num_cases;
    int          error_count;
    int          seed;

    qla_ctrl u_dut (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .credit     (credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .fb         (fb),
        .board_id   (board_id),
        .cmd        (cmd),
        .amp_active (amp_active)
    );

    bind reg_port qla_ctrl_asserts u_asserts (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .count     (count),
        .push      (push),
        .pop       (pop),
        .head_op   (head_req.op),
        .credit    (credit),
        .rsp_valid (rsp_valid)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    // ------------------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------------------
    task automatic fail_now(input string why);
        error_count++;
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
            fail_now($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
                               $time, name, got, want));
    endtask

    // ------------------------------------------------------------------------
    // host model
    // ------------------------------------------------------------------------
    // setpoint rule: chan 1..4, offset 1, low half of wdata
    function automatic void update_shadow(input logic [15:0] addr, input logic [31:0] wdata);
        if (addr[15:8] == 8'h00 && addr[7:4] >= 4'd1 && addr[7:4] <= 4'(NUM_AXES) &&
            addr[3:0] == OFF_DAC_CTRL)
            shadow_cmd[int'(addr[7:4]) - 1] = wdata[15:0];
    endfunction

    // called just after a falling edge, returns one falling edge later
    task automatic send_req(input reg_op_e op, input logic [15:0] addr,
                            input logic [31:0] wdata, input logic [31:0] want);
        while (host_credits == 0)
            @(negedge sysclk);                      // out of credit, hold off
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        req_valid = 1'b1;
        host_credits--;
        if (op == REG_READ)
            exp_q.push_back(want);
        else
            update_shadow(addr, wdata);
        @(negedge sysclk);
        req_valid = 1'b0;
    endtask

    // gives up after DRAIN_CYCLES, the final checks catch what is still owed
    task automatic drain_queue();
        int waited;
        waited = 0;
        while ((host_credits != REQ_DEPTH || exp_q.size() != 0) &&
               waited < DRAIN_CYCLES) begin
            @(negedge sysclk);
            waited++;
        end
    endtask

    // credit and response monitor, flop outputs taken before the edge updates
    always @(posedge sysclk) begin
        if (rst_n) begin
            if (credit) begin
                host_credits++;
                if (host_credits > REQ_DEPTH)
                    fail_now("credit returned with no request outstanding");
            end
            if (rsp_valid) begin
                if (exp_q.size() == 0)
                    fail_now("read response arrived with no read outstanding");
                else
                    check_value("rsp_data", rsp_data, exp_q.pop_front());
            end
        end
    end

    // mixed setpoint writes and reads, mostly back to back
    task automatic run_burst(input int n_req);
        int          axis;
        int          kind;
        int          gap;
        logic [31:0] val;
        for (int i = 0; i < n_req; i++) begin
            axis = $random(seed) & 32'h3;
            kind = $random(seed) & 32'h3;
            val  = $random(seed);
            gap  = $random(seed) & 32'h7;
            if (kind < 2)
                send_req(REG_WRITE, {8'h00, 4'(axis + 1), OFF_DAC_CTRL}, val, '0);
            else if (kind == 2)
                send_req(REG_READ, {8'h00, 4'(axis + 1), OFF_DAC_CTRL}, '0,
                         {16'h0000, shadow_cmd[axis]});
            else
                send_req(REG_READ, {8'h00, 4'(axis + 1), OFF_ADC_DATA}, '0,
                         {16'h0000, fb[axis]});
            if (gap < 3)
                repeat (gap) @(negedge sysclk);     // short idle now and then
        end
    endtask

    // ------------------------------------------------------------------------
    // case file
    // ------------------------------------------------------------------------
    task automatic load_cases();
        $readmemh("verification/qla_ctrl_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES &&
               !$isunknown(case_mem[num_cases*WORDS_PER_CASE]) &&
               case_mem[num_cases*WORDS_PER_CASE] != OP_END)
            num_cases++;
        if (num_cases == 0)
            fail_now("case file is empty or could not be read");
    endtask

    task automatic run_case(input int n);
        int          base;
        logic [31:0] op;
        logic [15:0] addr;
        logic [31:0] wdata;
        logic [31:0] want;
        cur_vec_t    line_fb;
        base  = n * WORDS_PER_CASE;
        op    = case_mem[base];
        addr  = case_mem[base + 1][15:0];
        wdata = case_mem[base + 2];
        want  = case_mem[base + 7];
        for (int k = 0; k < NUM_AXES; k++)
            line_fb[k] = case_mem[base + 3 + k][15:0];
        if (line_fb != fb) begin
            drain_queue();                          // reads in flight keep the old fb
            fb = line_fb;
        end
        case (op)
            OP_READ:  send_req(REG_READ, addr, '0, want);
            OP_WRITE: send_req(REG_WRITE, addr, wdata, '0);
            OP_AMP: begin
                drain_queue();
                repeat (SAFETY_LIMIT + 2) @(negedge sysclk);   // let the trip settle
                check_value("amp_active", 32'(amp_active), want);
            end
            OP_CMD: begin
                drain_queue();
                check_value($sformatf("cmd[%0d]", int'(addr) - 1),
                            32'(cmd[int'(addr) - 1]), want);
            end
            OP_BURST: run_burst(int'(addr));
            default:  fail_now($sformatf("unknown operation %h on case line %0d", op, n));
        endcase
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        fb           = '0;
        board_id     = BOARD_ID;
        host_credits = REQ_DEPTH;
        error_count  = 0;
        seed         = 32'h72d48528;
        for (int i = 0; i < NUM_AXES; i++)
            shadow_cmd[i] = 16'h0000;
        load_cases();
        repeat (RST_CYCLES) @(negedge sysclk);
        rst_n = 1'b1;
        for (int n = 0; n < num_cases; n++)
            run_case(n);
        drain_queue();
        check_value("host_credits", 32'(host_credits), 32'(REQ_DEPTH));
        check_value("outstanding reads", 32'(exp_q.size()), 32'd0);
        for (int i = 0; i < NUM_AXES; i++)
            check_value($sformatf("cmd[%0d]", i), 32'(cmd[i]), 32'(shadow_cmd[i]));
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin : watchdog
        wait (num_cases > 0);
        repeat (num_cases * CYCLES_PER_CASE + RST_CYCLES) @(posedge sysclk);
        fail_now("watchdog timeout, the cases did not finish in time");
    end

endmodule

`default_nettype wire

// ==== qla_ctrl.f ====
design/qla_pkg.sv
design/reg_port.sv
design/dac_regs.sv
design/safety_check.sv
design/board_regs.sv
design/qla_ctrl.sv
verification/qla_ctrl_asserts.sv
verification/qla_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run for the QLA controller core testbench

VERILATOR ?= verilator
TOP       ?= qla_ctrl_tb
FILELIST  ?= qla_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

# pass or fail comes from the log, not from the exit status of the model
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/qla_ctrl_cases.txt ====
// op addr wdata fb1 fb2 fb3 fb4 expect  (all hex, fb index 1 is axis 1)
// op 0 read, 1 write, 2 check amp_active, 3 check cmd of axis addr, 4 burst, f end
0 0000 00000000 0000 0000 0000 0000 0a000000
0 0011 00000000 0000 0000 0000 0000 00000000
0 0021 00000000 0000 0000 0000 0000 00000000
0 0031 00000000 0000 0000 0000 0000 00000000
0 0041 00000000 0000 0000 0000 0000 00000000
2 0000 00000000 0000 0000 0000 0000 00000000
1 0011 abcd1234 0000 0000 0000 0000 00000000
1 0031 00005a5a 0000 0000 0000 0000 00000000
0 0011 00000000 0000 0000 0000 0000 00001234
0 0031 00000000 0000 0000 0000 0000 00005a5a
3 0001 00000000 0000 0000 0000 0000 00001234
3 0003 00000000 0000 0000 0000 0000 00005a5a
1 0012 0000ffff 0000 0000 0000 0000 00000000
1 0051 00007777 0000 0000 0000 0000 00000000
1 0111 00007777 0000 0000 0000 0000 00000000
0 0011 00000000 0000 0000 0000 0000 00001234
0 0012 00000000 0000 0000 0000 0000 00000000
0 0051 00000000 0000 0000 0000 0000 00000000
0 0010 00000000 0100 0200 0300 0400 00000100
0 0040 00000000 0100 0200 0300 0400 00000400
1 0000 0000010f 0000 0000 0000 0000 00000000
2 0000 00000000 0000 0000 0000 0000 0000000f
0 0000 00000000 0000 0000 0000 0000 0a00000f
2 0000 00000000 2468 0000 0000 0000 0000000f
2 0000 00000000 2469 0000 0000 0000 0000000e
0 0000 00000000 2469 0000 0000 0000 0a00010f
1 0000 0000010f 0000 0000 0000 0000 00000000
2 0000 00000000 0000 0000 0000 0000 0000000f
0 0000 00000000 0000 0000 0000 0000 0a00000f
1 0000 00000005 0000 0000 0000 0000 00000000
2 0000 00000000 0000 0000 0000 0000 00000005
4 000c 00000000 0000 0000 0000 0000 00000000
f 0000 00000000 0000 0000 0000 0000 00000000
